// ==== verilog/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // register index into the 32-entry integer file
  typedef logic [4:0] reg_idx_t;

  localparam reg_idx_t zero_reg = 5'd0;

  // major opcodes of the base integer set
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_immari = 7'b0010011;
  localparam logic [6:0] op_regari = 7'b0110011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;

  // register-register layout, also the view used for rd
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // store layout, rd bits hold the low immediate here
  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    s_fmt_t s_fmt;
  } instr_u;

endpackage

// ==== verilog/pipe_ctrl_pkg.sv ====
package pipe_ctrl_pkg;

  // decode-stage instruction summary
  typedef struct packed {
    rv_isa_pkg::reg_idx_t rs1;
    rv_isa_pkg::reg_idx_t rs2;
    // zero_reg when nothing is written back
    rv_isa_pkg::reg_idx_t rd;
    logic                 reg1_fwd_ok;
    logic                 reg2_fwd_ok;
    // rs2 carries the store data
    logic                 store_data;
    logic                 is_load;
    logic                 is_branch;
    logic                 is_jal;
    logic                 is_jalr;
    logic                 is_store;
  } instr_class_t;

  // destination record carried down stages 3 and 4
  typedef struct packed {
    rv_isa_pkg::reg_idx_t rd;
    logic                 is_load;
  } stage_dest_t;

  // forwarding selects toward the datapath muxes
  typedef struct packed {
    // stage 3 alu result into decode operands
    logic alu_reg1;
    logic alu_reg2;
    // stage 4 memory or writeback data into decode operands
    logic dm_reg1;
    logic dm_reg2;
    // load data into the store operand, one cycle late
    logic dm_alu;
  } fwd_sel_t;

  // next pc select
  typedef logic [1:0] pc_sel_t;

  localparam pc_sel_t pc_plus4 = 2'd0;
  localparam pc_sel_t pc_hold  = 2'd1;
  localparam pc_sel_t pc_jump  = 2'd2;
  localparam pc_sel_t pc_jalr  = 2'd3;

  // empty stage record used for squashed slots
  localparam stage_dest_t bubble_dest = '{rd: rv_isa_pkg::zero_reg, is_load: 1'b0};

endpackage

// ==== verilog/instr_classify.sv ====
`timescale 1ns/10ps

module instr_classify (
  input  rv_isa_pkg::instr_u          id_instr,
  output pipe_ctrl_pkg::instr_class_t cls
);

  logic [6:0] opcode;
  logic       is_immari;
  logic       is_regari;
  logic       writes_rd;

  assign opcode    = id_instr.r_fmt.opcode;
  assign is_immari = opcode == rv_isa_pkg::op_immari;
  assign is_regari = opcode == rv_isa_pkg::op_regari;

  // every format that carries a real rd field
  assign writes_rd = opcode == rv_isa_pkg::op_load  || is_immari || is_regari ||
                     opcode == rv_isa_pkg::op_jal   || opcode == rv_isa_pkg::op_jalr ||
                     opcode == rv_isa_pkg::op_lui   || opcode == rv_isa_pkg::op_auipc;

  always_comb begin
    cls.is_load   = opcode == rv_isa_pkg::op_load;
    cls.is_store  = opcode == rv_isa_pkg::op_store;
    cls.is_branch = opcode == rv_isa_pkg::op_branch;
    cls.is_jal    = opcode == rv_isa_pkg::op_jal;
    cls.is_jalr   = opcode == rv_isa_pkg::op_jalr;

    // source fields sit at the same bits in every format
    cls.rs1 = id_instr.r_fmt.rs1;
    cls.rs2 = id_instr.r_fmt.rs2;

    cls.rd = writes_rd ? id_instr.r_fmt.rd : rv_isa_pkg::zero_reg;

    // which source fields are really read as registers
    cls.reg1_fwd_ok = cls.is_load || cls.is_store || is_immari || is_regari ||
                      cls.is_branch || cls.is_jalr;
    cls.reg2_fwd_ok = cls.is_load || is_regari || cls.is_branch;
    cls.store_data  = cls.is_store;
  end

endmodule

// ==== verilog/dest_tracker.sv ====
`timescale 1ns/10ps

module dest_tracker (
  input  logic                         clk,
  input  logic                         rst_n,
  input  pipe_ctrl_pkg::instr_class_t  cls,
  input  logic                         stall,
  input  logic                         insert_nop,
  output pipe_ctrl_pkg::stage_dest_t   st3,
  output pipe_ctrl_pkg::stage_dest_t   st4
);

  pipe_ctrl_pkg::stage_dest_t dec_dest;
  logic                       squash;

  // record of the instruction leaving decode
  assign dec_dest.rd      = cls.rd;
  assign dec_dest.is_load = cls.is_load;

  // held or flushed decode slot enters execute as an empty record
  assign squash = stall || insert_nop;

  // stage 3 register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      st3 <= pipe_ctrl_pkg::bubble_dest;
    end else if (squash) begin
      st3 <= pipe_ctrl_pkg::bubble_dest;
    end else begin
      st3 <= dec_dest;
    end
  end

  // stage 4 just follows stage 3
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      st4 <= pipe_ctrl_pkg::bubble_dest;
    end else begin
      st4 <= st3;
    end
  end

endmodule

// ==== verilog/hazard_detect.sv ====
`timescale 1ns/10ps

module hazard_detect (
  input  logic                         clk,
  input  logic                         rst_n,
  input  pipe_ctrl_pkg::instr_class_t  cls,
  input  pipe_ctrl_pkg::stage_dest_t   st3,
  input  pipe_ctrl_pkg::stage_dest_t   st4,
  output logic                         stall,
  output pipe_ctrl_pkg::fwd_sel_t      fwd
);

  logic st3_valid;
  logic st4_valid;
  logic st3_rs1_hit;
  logic st3_rs2_hit;
  logic st4_rs1_hit;
  logic st4_rs2_hit;
  logic load_rs1_use;
  logic load_rs2_use;
  logic dm_alu_next;
  logic dm_alu_q;

  // register zero is never a real producer
  assign st3_valid = st3.rd != rv_isa_pkg::zero_reg;
  assign st4_valid = st4.rd != rv_isa_pkg::zero_reg;

  assign st3_rs1_hit = st3_valid && st3.rd == cls.rs1;
  assign st3_rs2_hit = st3_valid && st3.rd == cls.rs2;
  assign st4_rs1_hit = st4_valid && st4.rd == cls.rs1;
  assign st4_rs2_hit = st4_valid && st4.rd == cls.rs2;

  // load result not ready until stage 4
  // rs1 is read by load, jalr, immari, store, branch and regari
  assign load_rs1_use = cls.reg1_fwd_ok && st3_rs1_hit;
  // rs2 only matters for branch and regari here, a store rs2 is forwarded late
  assign load_rs2_use = cls.reg2_fwd_ok && !cls.is_load && st3_rs2_hit;

  assign stall = st3.is_load && (load_rs1_use || load_rs2_use);

  // stage 3 is always an alu result, jumps never produce into decode
  assign fwd.alu_reg1 = st3_rs1_hit && cls.reg1_fwd_ok;
  assign fwd.alu_reg2 = st3_rs2_hit && cls.reg2_fwd_ok;

  // the younger alu value overrides stage 4
  assign fwd.dm_reg1 = st4_rs1_hit && cls.reg1_fwd_ok && !fwd.alu_reg1;
  // store data can take stage 4 too, covers write-x-store spacing
  assign fwd.dm_reg2 = st4_rs2_hit && (cls.reg2_fwd_ok || cls.store_data) &&
                       !fwd.alu_reg2;

  // store rs2 produced by the instruction right ahead of it
  assign dm_alu_next = st3_rs2_hit && cls.store_data;

  // the store is in stage 3 when the data arrives from stage 4
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dm_alu_q <= 1'b0;
    end else begin
      dm_alu_q <= dm_alu_next;
    end
  end

  assign fwd.dm_alu = dm_alu_q;

endmodule

// ==== verilog/flow_control.sv ====
`timescale 1ns/10ps

module flow_control (
  input  logic                         clk,
  input  logic                         rst_n,
  input  pipe_ctrl_pkg::instr_class_t  cls,
  input  logic                         branch_taken,
  input  logic                         stall,
  output pipe_ctrl_pkg::pc_sel_t       next_pc_sel,
  output logic                         insert_nop
);

  logic prev_jalr;
  logic jump;

  // jalr target is known one cycle after decode
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_jalr <= 1'b0;
    end else begin
      prev_jalr <= cls.is_jalr;
    end
  end

  assign jump = (branch_taken && cls.is_branch) || cls.is_jal;

  always_comb begin
    if (prev_jalr) begin
      next_pc_sel = pipe_ctrl_pkg::pc_jalr;
    end else if (jump) begin
      next_pc_sel = pipe_ctrl_pkg::pc_jump;
    end else if (stall || cls.is_jalr) begin
      next_pc_sel = pipe_ctrl_pkg::pc_hold;
    end else begin
      next_pc_sel = pipe_ctrl_pkg::pc_plus4;
    end
  end

  // flush the wrong-path slot on any redirect
  assign insert_nop = cls.is_jalr || prev_jalr || jump;

endmodule

// ==== verilog/pipe_ctrl_top.sv ====
`timescale 1ns/10ps

module pipe_ctrl_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  rv_isa_pkg::instr_u        id_instr,
  input  logic                      branch_taken,
  output logic                      stall,
  output pipe_ctrl_pkg::fwd_sel_t   fwd,
  output pipe_ctrl_pkg::pc_sel_t    next_pc_sel,
  output logic                      insert_nop
);

  pipe_ctrl_pkg::instr_class_t cls;
  pipe_ctrl_pkg::stage_dest_t  st3;
  pipe_ctrl_pkg::stage_dest_t  st4;

  // decode view of the incoming word
  instr_classify i_instr_classify (
    .id_instr (id_instr),
    .cls      (cls)
  );

  // stage 3 and 4 destinations
  dest_tracker i_dest_tracker (
    .clk        (clk),
    .rst_n      (rst_n),
    .cls        (cls),
    .stall      (stall),
    .insert_nop (insert_nop),
    .st3        (st3),
    .st4        (st4)
  );

  hazard_detect i_hazard_detect (
    .clk   (clk),
    .rst_n (rst_n),
    .cls   (cls),
    .st3   (st3),
    .st4   (st4),
    .stall (stall),
    .fwd   (fwd)
  );

  // pc select and flush
  flow_control i_flow_control (
    .clk          (clk),
    .rst_n        (rst_n),
    .cls          (cls),
    .branch_taken (branch_taken),
    .stall        (stall),
    .next_pc_sel  (next_pc_sel),
    .insert_nop   (insert_nop)
  );

endmodule

// ==== bench/pipe_ctrl_checker.sv ====
`timescale 1ns/10ps

module pipe_ctrl_checker (
  input logic                         clk,
  input logic                         rst_n,
  input pipe_ctrl_pkg::instr_class_t  cls,
  input logic                         stall,
  input pipe_ctrl_pkg::fwd_sel_t      fwd,
  input pipe_ctrl_pkg::pc_sel_t       next_pc_sel,
  input logic                         insert_nop
);

  int fail_count = 0;

  // a hold only comes from a load-use stall or a jalr waiting for its target
  hold_cause: assert property (@(posedge clk) disable iff (!rst_n)
      next_pc_sel == pipe_ctrl_pkg::pc_hold |-> stall || cls.is_jalr)
    else begin
      $error("pc hold without a stall or a jalr in decode");
      fail_count++;
    end

  // rs1 takes one forward source at most
  reg1_one_source: assert property (@(posedge clk) disable iff (!rst_n)
      !(fwd.alu_reg1 && fwd.dm_reg1))
    else begin
      $error("alu and memory forwards both selected for rs1");
      fail_count++;
    end

  jalr_flush: assert property (@(posedge clk) disable iff (!rst_n)
      next_pc_sel == pipe_ctrl_pkg::pc_jalr |-> insert_nop)
    else begin
      $error("jalr redirect without a nop");
      fail_count++;
    end

endmodule

bind pipe_ctrl_top pipe_ctrl_checker i_checker (
  .clk         (clk),
  .rst_n       (rst_n),
  .cls         (cls),
  .stall       (stall),
  .fwd         (fwd),
  .next_pc_sel (next_pc_sel),
  .insert_nop  (insert_nop)
);

// ==== bench/pipe_ctrl_monitor.sv ====
`timescale 1ns/10ps

module pipe_ctrl_monitor (
  input  logic                     clk,
  input  logic                     rst_n,
  input  rv_isa_pkg::instr_u       id_instr,
  input  logic                     branch_taken,
  input  logic                     stall,
  input  pipe_ctrl_pkg::fwd_sel_t  fwd,
  input  pipe_ctrl_pkg::pc_sel_t   next_pc_sel,
  input  logic                     insert_nop,
  input  int                       test_num,
  input  logic                     done,
  output int                       errors
);

  // model of the stage 3 and 4 destinations
  pipe_ctrl_pkg::stage_dest_t m_st3;
  pipe_ctrl_pkg::stage_dest_t m_st4;
  logic                       m_prev_jalr;
  logic                       m_dm_alu;
  logic [6:0]                 opc;
  rv_isa_pkg::reg_idx_t       rd;
  logic                       is_load;
  logic                       is_store;
  logic                       is_immari;
  logic                       is_regari;
  logic                       is_branch;
  logic                       is_jal;
  logic                       is_jalr;
  logic                       use_rs1;
  logic                       use_rs2;
  logic                       hit3_rs1;
  logic                       hit3_rs2;
  logic                       hit4_rs1;
  logic                       hit4_rs2;
  logic                       jump;
  logic                       exp_stall;
  pipe_ctrl_pkg::fwd_sel_t    exp_fwd;
  pipe_ctrl_pkg::pc_sel_t     exp_pc;
  logic                       exp_nop;
  int                         cur_test = 1;
  int                         test_checks = 0;
  int                         test_errors = 0;
  int                         total_checks = 0;
  int                         total_errors = 0;
  logic                       finished = 1'b0;

  assign errors = total_errors;

  always_comb begin
    opc       = id_instr.r_fmt.opcode;
    is_load   = opc == rv_isa_pkg::op_load;
    is_store  = opc == rv_isa_pkg::op_store;
    is_immari = opc == rv_isa_pkg::op_immari;
    is_regari = opc == rv_isa_pkg::op_regari;
    is_branch = opc == rv_isa_pkg::op_branch;
    is_jal    = opc == rv_isa_pkg::op_jal;
    is_jalr   = opc == rv_isa_pkg::op_jalr;
    // stores and branches write nothing
    rd = (is_store || is_branch) ? rv_isa_pkg::zero_reg : id_instr.r_fmt.rd;
    use_rs1 = is_load || is_store || is_immari || is_regari || is_branch || is_jalr;
    use_rs2 = is_load || is_regari || is_branch;
    hit3_rs1 = m_st3.rd != rv_isa_pkg::zero_reg && m_st3.rd == id_instr.r_fmt.rs1;
    hit3_rs2 = m_st3.rd != rv_isa_pkg::zero_reg && m_st3.rd == id_instr.r_fmt.rs2;
    hit4_rs1 = m_st4.rd != rv_isa_pkg::zero_reg && m_st4.rd == id_instr.r_fmt.rs1;
    hit4_rs2 = m_st4.rd != rv_isa_pkg::zero_reg && m_st4.rd == id_instr.r_fmt.rs2;
    exp_stall = m_st3.is_load &&
                ((hit3_rs1 && (is_load || is_jalr || is_immari || is_store)) ||
                 ((hit3_rs1 || hit3_rs2) && (is_branch || is_regari)));
    exp_fwd.alu_reg1 = hit3_rs1 && use_rs1;
    exp_fwd.alu_reg2 = hit3_rs2 && use_rs2;
    exp_fwd.dm_reg1  = hit4_rs1 && use_rs1 && !exp_fwd.alu_reg1;
    exp_fwd.dm_reg2  = hit4_rs2 && (use_rs2 || is_store) && !exp_fwd.alu_reg2;
    exp_fwd.dm_alu   = m_dm_alu;
    jump = (is_branch && branch_taken) || is_jal;
    if (m_prev_jalr) begin
      exp_pc = pipe_ctrl_pkg::pc_jalr;
    end else if (jump) begin
      exp_pc = pipe_ctrl_pkg::pc_jump;
    end else if (exp_stall || is_jalr) begin
      exp_pc = pipe_ctrl_pkg::pc_hold;
    end else begin
      exp_pc = pipe_ctrl_pkg::pc_plus4;
    end
    exp_nop = is_jalr || m_prev_jalr || jump;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_st3       <= '0;
      m_st4       <= '0;
      m_prev_jalr <= 1'b0;
      m_dm_alu    <= 1'b0;
    end else begin
      // a held or flushed slot enters stage 3 empty
      m_st3       <= (exp_stall || exp_nop) ? '0 : {rd, is_load};
      m_st4       <= m_st3;
      m_prev_jalr <= is_jalr;
      m_dm_alu    <= is_store && hit3_rs2;
    end
  end

  function automatic string test_name(input int n);
    case (n)
      1: return "reset idle";
      2: return "load use";
      3: return "forwarding priority";
      4: return "control flow";
      5: return "bubble tracking";
      default: return "random stream";
    endcase
  endfunction

  task automatic compare(input string name, input logic [1:0] exp, input logic [1:0] act);
    test_checks++;
    total_checks++;
    if (act !== exp) begin
      test_errors++;
      total_errors++;
      $display("Fail time=%0t signal=%s expected=%0d actual=%0d", $time, name, exp, act);
    end
  endtask

  task automatic report_test();
    $display("test %0d %s: %0d checks, %0d errors", cur_test, test_name(cur_test),
             test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  // outputs are settled by the falling edge
  always @(negedge clk) begin
    if (rst_n && !finished) begin
      if (test_num != cur_test) begin
        report_test();
        cur_test = test_num;
      end
      if (done) begin
        report_test();
        $display("summary: %0d tests, %0d checks, %0d errors", cur_test, total_checks,
                 total_errors);
        finished = 1'b1;
      end else begin
        compare("stall", {1'b0, exp_stall}, {1'b0, stall});
        compare("fwd.alu_reg1", {1'b0, exp_fwd.alu_reg1}, {1'b0, fwd.alu_reg1});
        compare("fwd.alu_reg2", {1'b0, exp_fwd.alu_reg2}, {1'b0, fwd.alu_reg2});
        compare("fwd.dm_reg1", {1'b0, exp_fwd.dm_reg1}, {1'b0, fwd.dm_reg1});
        compare("fwd.dm_reg2", {1'b0, exp_fwd.dm_reg2}, {1'b0, fwd.dm_reg2});
        compare("fwd.dm_alu", {1'b0, exp_fwd.dm_alu}, {1'b0, fwd.dm_alu});
        compare("next_pc_sel", exp_pc, next_pc_sel);
        compare("insert_nop", {1'b0, exp_nop}, {1'b0, insert_nop});
      end
    end
  end

endmodule

// ==== bench/pipe_ctrl_tb.sv ====
`timescale 1ns/10ps

module pipe_ctrl_tb;

  localparam int clk_period      = 40;
  localparam int reset_cycles    = 16;
  localparam int directed_cycles = 120;
  localparam int random_cycles   = 400;
  localparam int watchdog_cycles = reset_cycles + directed_cycles + random_cycles + 50;

  // addi x0, x0, 0
  localparam rv_isa_pkg::instr_u nop_word = 32'h0000_0013;

  logic                    clk = 1'b0;
  logic                    rst_n;
  rv_isa_pkg::instr_u      id_instr;
  logic                    branch_taken;
  logic                    stall;
  pipe_ctrl_pkg::fwd_sel_t fwd;
  pipe_ctrl_pkg::pc_sel_t  next_pc_sel;
  logic                    insert_nop;
  int                      test_num;
  int                      pending_test;
  logic                    done;
  int                      mon_errors;
  logic [31:0]             rng_state = 32'd78301;

  always #(clk_period / 2) clk = ~clk;

  pipe_ctrl_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .id_instr     (id_instr),
    .branch_taken (branch_taken),
    .stall        (stall),
    .fwd          (fwd),
    .next_pc_sel  (next_pc_sel),
    .insert_nop   (insert_nop)
  );

  pipe_ctrl_monitor i_monitor (
    .clk          (clk),
    .rst_n        (rst_n),
    .id_instr     (id_instr),
    .branch_taken (branch_taken),
    .stall        (stall),
    .fwd          (fwd),
    .next_pc_sel  (next_pc_sel),
    .insert_nop   (insert_nop),
    .test_num     (test_num),
    .done         (done),
    .errors       (mon_errors)
  );

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [6:0] pick_opcode(input logic [31:0] r);
    case (r % 32'd9)
      32'd0: return rv_isa_pkg::op_load;
      32'd1: return rv_isa_pkg::op_store;
      32'd2: return rv_isa_pkg::op_immari;
      32'd3: return rv_isa_pkg::op_regari;
      32'd4: return rv_isa_pkg::op_branch;
      32'd5: return rv_isa_pkg::op_jal;
      32'd6: return rv_isa_pkg::op_jalr;
      32'd7: return rv_isa_pkg::op_lui;
      default: return rv_isa_pkg::op_auipc;
    endcase
  endfunction

  // rd doubles as the low store immediate
  function automatic rv_isa_pkg::instr_u make_instr(input logic [6:0] opc,
      input rv_isa_pkg::reg_idx_t rd, input rv_isa_pkg::reg_idx_t rs1,
      input rv_isa_pkg::reg_idx_t rs2);
    rv_isa_pkg::instr_u w;
    w.r_fmt.funct7 = 7'd0;
    w.r_fmt.rs2    = rs2;
    w.r_fmt.rs1    = rs1;
    w.r_fmt.funct3 = 3'd0;
    w.r_fmt.rd     = rd;
    w.r_fmt.opcode = opc;
    return w;
  endfunction

  task automatic drive(input rv_isa_pkg::instr_u instr, input logic taken);
    @(posedge clk);
    #2;
    test_num     = pending_test;
    id_instr     = instr;
    branch_taken = taken;
  endtask

  task automatic nops(input int n);
    repeat (n) drive(nop_word, 1'b0);
  endtask

  initial begin
    logic [31:0] r;
    logic [6:0]  opc;
    rst_n        = 1'b0;
    id_instr     = nop_word;
    branch_taken = 1'b0;
    test_num     = 1;
    pending_test = 1;
    done         = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #2;
    rst_n = 1'b1;
    nops(8);

    // dependent consumers are presented twice, the stall holds them once
    pending_test = 2;
    drive(make_instr(rv_isa_pkg::op_load, 5'd1, 5'd2, 5'd0), 1'b0);
    repeat (2) drive(make_instr(rv_isa_pkg::op_regari, 5'd3, 5'd1, 5'd4), 1'b0);
    nops(2);
    drive(make_instr(rv_isa_pkg::op_load, 5'd2, 5'd3, 5'd0), 1'b0);
    repeat (2) drive(make_instr(rv_isa_pkg::op_branch, 5'd0, 5'd5, 5'd2), 1'b0);
    nops(2);
    drive(make_instr(rv_isa_pkg::op_load, 5'd3, 5'd1, 5'd0), 1'b0);
    repeat (2) drive(make_instr(rv_isa_pkg::op_immari, 5'd4, 5'd3, 5'd0), 1'b0);
    nops(2);
    drive(make_instr(rv_isa_pkg::op_load, 5'd4, 5'd1, 5'd0), 1'b0);
    repeat (2) drive(make_instr(rv_isa_pkg::op_store, 5'd0, 5'd4, 5'd6), 1'b0);
    nops(2);
    // store data from the load goes through the late forward
    drive(make_instr(rv_isa_pkg::op_load, 5'd5, 5'd1, 5'd0), 1'b0);
    drive(make_instr(rv_isa_pkg::op_store, 5'd2, 5'd6, 5'd5), 1'b0);
    nops(3);

    pending_test = 3;
    drive(make_instr(rv_isa_pkg::op_immari, 5'd3, 5'd1, 5'd0), 1'b0);
    drive(make_instr(rv_isa_pkg::op_regari, 5'd3, 5'd1, 5'd2), 1'b0);
    drive(make_instr(rv_isa_pkg::op_regari, 5'd6, 5'd3, 5'd3), 1'b0);
    repeat (2) drive(make_instr(rv_isa_pkg::op_immari, 5'd0, 5'd1, 5'd0), 1'b0);
    drive(make_instr(rv_isa_pkg::op_regari, 5'd5, 5'd0, 5'd0), 1'b0);
    drive(make_instr(rv_isa_pkg::op_lui, 5'd7, 5'd0, 5'd0), 1'b0);
    nops(1);
    drive(make_instr(rv_isa_pkg::op_regari, 5'd1, 5'd7, 5'd7), 1'b0);
    drive(make_instr(rv_isa_pkg::op_immari, 5'd2, 5'd1, 5'd0), 1'b0);
    nops(1);
    drive(make_instr(rv_isa_pkg::op_store, 5'd0, 5'd0, 5'd2), 1'b0);
    nops(2);

    pending_test = 4;
    drive(make_instr(rv_isa_pkg::op_branch, 5'd0, 5'd1, 5'd2), 1'b1);
    nops(1);
    drive(make_instr(rv_isa_pkg::op_branch, 5'd0, 5'd1, 5'd2), 1'b0);
    drive(make_instr(rv_isa_pkg::op_jal, 5'd1, 5'd0, 5'd0), 1'b0);
    nops(1);
    drive(make_instr(rv_isa_pkg::op_jalr, 5'd2, 5'd3, 5'd0), 1'b0);
    nops(2);

    // the flushed jal and the stalled immari must not reach stage 4
    pending_test = 5;
    drive(make_instr(rv_isa_pkg::op_jal, 5'd5, 5'd0, 5'd0), 1'b0);
    nops(1);
    drive(make_instr(rv_isa_pkg::op_regari, 5'd6, 5'd5, 5'd5), 1'b0);
    drive(make_instr(rv_isa_pkg::op_load, 5'd7, 5'd1, 5'd0), 1'b0);
    repeat (2) drive(make_instr(rv_isa_pkg::op_immari, 5'd6, 5'd7, 5'd0), 1'b0);
    drive(make_instr(rv_isa_pkg::op_regari, 5'd4, 5'd6, 5'd6), 1'b0);
    nops(2);

    // registers 0 to 7 keep matches frequent
    pending_test = 6;
    repeat (random_cycles) begin
      opc = pick_opcode(next_rand());
      r   = next_rand();
      drive(make_instr(opc, {2'b00, r[2:0]}, {2'b00, r[5:3]}, {2'b00, r[8:6]}), r[9]);
    end

    @(posedge clk);
    #2;
    done = 1'b1;
    @(negedge clk);
    #1;
    if (mon_errors == 0 && i_dut.i_checker.fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired before the tests finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== compile.f ====
verilog/rv_isa_pkg.sv
verilog/pipe_ctrl_pkg.sv
verilog/instr_classify.sv
verilog/dest_tracker.sv
verilog/hazard_detect.sv
verilog/flow_control.sv
verilog/pipe_ctrl_top.sv
bench/pipe_ctrl_checker.sv
bench/pipe_ctrl_monitor.sv
bench/pipe_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module pipe_ctrl_tb -f compile.f -o sim_pipe_ctrl

# the log decides pass or fail, so a failing run must not stop the script here
./obj_dir/sim_pipe_ctrl +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

grep -q "TEST PASSED" sim.log
